//--- sources.f
hdl/msx_io_pkg.sv
hdl/msx_vdp_pkg.sv
hdl/cpu_clock_enable.sv
hdl/vdp_port.sv
hdl/ppi_psg_ports.sv
hdl/slot_memory.sv
hdl/msx_chipset.sv
sim/tb_msx_chipset.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MSX chipset testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f \
  --top-module tb_msx_chipset -o tb_msx_chipset
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_msx_chipset)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'TEST RESULT: PASS'; then
  exit 0
fi
exit 1

//--- sim/tb_msx_chipset.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msx_chipset
  import msx_io_pkg::*;
  import msx_vdp_pkg::*;
();

  localparam int EDGE_TIMEOUT = 20; // Cycles allowed between edge strobes
  localparam int RAM_WORDS    = 8;
  localparam int VRAM_BURST   = 6;

  logic        cpuClock;
  logic        n_hard_reset;
  cpu_addr_t   i_addr;
  cpu_data_t   i_data_out;
  logic        i_n_wr, i_n_rd, i_n_mreq, i_n_iorq;
  cpu_data_t   i_keyboard_row;
  logic [5:0]  i_buttons;
  logic        i_vblank;
  cpu_data_t   i_rom_data;
  logic        i_rom_32k;
  cpu_data_t   o_data_in;
  logic        o_cpu_clock_enable, o_cpu_clock_edge, o_n_int, o_psg_write;
  vdp_mode_e   o_vdp_mode;
  logic [3:0]  o_keyboard_select;
  logic [14:0] o_rom_addr;
  psg_reg_t    o_psg_reg;

  integer      seed;
  int          errors;
  int          timeouts;
  int          psg_writes;
  logic [3:0]  cycles_since_edge;
  logic        seen_edge;
  cpu_addr_t   ram_addr [RAM_WORDS];
  cpu_data_t   ram_data [RAM_WORDS];
  cpu_data_t   vram_data [VRAM_BURST];

  msx_chipset #(
    .CLOCK_DIVIDE   (7),
    .VRAM_ADDR_BITS (14)
  ) i_dut (
    .cpuClock (cpuClock), .n_hard_reset (n_hard_reset), .i_addr (i_addr),
    .i_data_out (i_data_out), .i_n_wr (i_n_wr), .i_n_rd (i_n_rd), .i_n_mreq (i_n_mreq),
    .i_n_iorq (i_n_iorq), .i_keyboard_row (i_keyboard_row), .i_buttons (i_buttons),
    .i_vblank (i_vblank), .i_rom_data (i_rom_data), .i_rom_32k (i_rom_32k),
    .o_data_in (o_data_in), .o_cpu_clock_enable (o_cpu_clock_enable),
    .o_cpu_clock_edge (o_cpu_clock_edge), .o_n_int (o_n_int), .o_vdp_mode (o_vdp_mode),
    .o_keyboard_select (o_keyboard_select), .o_rom_addr (o_rom_addr),
    .o_psg_write (o_psg_write), .o_psg_reg (o_psg_reg)
  );

  always #50 cpuClock = ~cpuClock; // 100 ns period

  // ==================================================
  // Edge strobe spacing
  // ==================================================
  always @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      cycles_since_edge <= '0;
      seen_edge         <= 1'b0;
    end else if (o_cpu_clock_edge) begin
      cycles_since_edge <= '0;
      seen_edge         <= 1'b1;
    end else begin
      cycles_since_edge <= cycles_since_edge + 4'd1;
    end
  end

  // Edge strobes that carried a PSG value write
  always @(negedge cpuClock) begin
    if (o_cpu_clock_edge && o_psg_write) begin
      psg_writes <= psg_writes + 1;
    end
  end

  a_edge_period : assert property (@(negedge cpuClock) disable iff (!n_hard_reset)
    (seen_edge && o_cpu_clock_edge) |-> (cycles_since_edge == 4'd6))
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: edge strobe came early", $time);
    end

  a_edge_gap : assert property (@(negedge cpuClock) disable iff (!n_hard_reset)
    seen_edge |-> (cycles_since_edge <= 4'd6))
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: edge strobe missing after 7 cycles", $time);
    end

  // Strobe exactly where the enable goes high
  a_enable_rise : assert property (@(negedge cpuClock) disable iff (!n_hard_reset)
    o_cpu_clock_edge == $rose(o_cpu_clock_enable))
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: edge strobe not at the rise of the enable", $time);
    end

  a_reset_quiet : assert property (@(negedge cpuClock)
    !n_hard_reset |-> (!o_cpu_clock_edge && !o_cpu_clock_enable))
    else begin
      errors = errors + 1;
      $display("Mismatch at %0t: clock enable or edge strobe high during reset", $time);
    end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic finish_run();
    $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got == exp) else begin
      errors = errors + 1;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // Ends at the negedge inside an edge cycle
  task automatic wait_for_edge();
    int waited;
    waited = 0;
    @(negedge cpuClock);
    while (!o_cpu_clock_edge && waited < EDGE_TIMEOUT) begin
      waited++;
      @(negedge cpuClock);
    end
    if (!o_cpu_clock_edge) begin
      timeouts = timeouts + 1;
      $display("Timeout: no CPU clock edge strobe within %0d cycles", EDGE_TIMEOUT);
      finish_run();
    end
  endtask

  // One access for a full period, then back to idle
  task automatic bus_access(input logic is_io, input logic is_write, input cpu_addr_t addr,
                            input cpu_data_t wdata, output cpu_data_t rdata);
    wait_for_edge();
    @(posedge cpuClock);
    i_addr     <= addr;
    i_data_out <= wdata;
    i_n_iorq   <= !is_io;
    i_n_mreq   <= is_io;
    i_n_wr     <= !is_write;
    i_n_rd     <= is_write;
    wait_for_edge();
    rdata = o_data_in; // Stable just before the strobe that ends the access
    @(posedge cpuClock);
    i_n_iorq   <= 1'b1;
    i_n_mreq   <= 1'b1;
    i_n_wr     <= 1'b1;
    i_n_rd     <= 1'b1;
  endtask

  task automatic io_write(input io_port_t port, input cpu_data_t data);
    cpu_data_t unused;
    bus_access(1'b1, 1'b1, {8'h00, port}, data, unused);
  endtask

  task automatic io_read(input io_port_t port, output cpu_data_t data);
    bus_access(1'b1, 1'b0, {8'h00, port}, 8'h00, data);
  endtask

  task automatic vdp_set_addr(input logic [13:0] addr, input logic for_write);
    io_write(VDP_CTRL_PORT, addr[7:0]);
    io_write(VDP_CTRL_PORT, {1'b0, for_write, addr[13:8]});
  endtask

  task automatic vdp_write_reg(input logic [2:0] index, input cpu_data_t value);
    io_write(VDP_CTRL_PORT, value);
    io_write(VDP_CTRL_PORT, {5'b10000, index});
  endtask

  // TMS9918 mode bits M1 (R1.4), M2 (R1.3), M3 (R0.1)
  function automatic vdp_mode_e expected_mode(input logic m1, input logic m2, input logic m3);
    case ({m1, m2, m3})
      3'b000:  return GRAPHIC1;
      3'b100:  return TEXT;
      3'b001,
      3'b101:  return GRAPHIC2;
      default: return MULTICOLOR; // M2 wins over the others
    endcase
  endfunction

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin
    cpu_data_t   rd;
    cpu_data_t   value;
    cpu_data_t   expect_c;
    cpu_addr_t   addr;
    logic [2:0]  bit_index;
    logic [13:0] vram_base;
    cpuClock = 1'b0;
    n_hard_reset = 1'b0;
    i_addr = '0;
    i_data_out = '0;
    i_n_wr = 1'b1;
    i_n_rd = 1'b1;
    i_n_mreq = 1'b1;
    i_n_iorq = 1'b1;
    i_keyboard_row = 8'hFF;
    i_buttons = 6'h3F;
    i_vblank = 1'b0;
    i_rom_data = '0;
    i_rom_32k = 1'b0;
    seed = 32'hb7b5_133b;
    errors = 0;
    timeouts = 0;
    psg_writes = 0;
    repeat (3) @(posedge cpuClock);
    n_hard_reset <= 1'b1;

    // RAM in pages 2 and 3, slot 0 everywhere after reset
    for (int i = 0; i < RAM_WORDS; i++) begin
      ram_addr[i] = {1'b1, 3'(i), 12'($random(seed))};
      ram_data[i] = 8'($random(seed));
      bus_access(1'b0, 1'b1, ram_addr[i], ram_data[i], rd);
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      bus_access(1'b0, 1'b0, ram_addr[i], 8'h00, rd);
      check_value("RAM read back", 16'(rd), 16'(ram_data[i]));
    end
    addr = {2'b00, 14'($random(seed))};
    bus_access(1'b0, 1'b1, addr, 8'($random(seed)) | 8'h01, rd);
    bus_access(1'b0, 1'b0, addr, 8'h00, rd);
    check_value("page 0 RAM write ignored", 16'(rd), 16'h0000);

    // PPI ports A, B and C
    value = 8'($random(seed));
    io_write(PPI_A_PORT, value);
    io_read(PPI_A_PORT, rd);
    check_value("PPI port A", 16'(rd), 16'(value));
    io_write(PPI_A_PORT, 8'h00);
    expect_c = 8'($random(seed));
    io_write(PPI_C_PORT, expect_c);
    io_read(PPI_C_PORT, rd);
    check_value("PPI port C", 16'(rd), 16'(expect_c));
    for (int i = 0; i < 4; i++) begin
      bit_index = 3'($random(seed));
      value     = {4'b0000, bit_index, i[0]}; // Alternate clear and set
      expect_c[bit_index] = i[0];
      io_write(PPI_CMD_PORT, value);
      io_read(PPI_C_PORT, rd);
      check_value("PPI bit set/reset", 16'(rd), 16'(expect_c));
      check_value("keyboard select", 16'(o_keyboard_select), 16'(expect_c[3:0]));
    end
    @(posedge cpuClock);
    i_keyboard_row <= 8'($random(seed));
    io_read(PPI_B_PORT, rd);
    check_value("PPI port B", 16'(rd), 16'(i_keyboard_row));

    // VRAM burst write then burst read
    vram_base = 14'($random(seed));
    vdp_set_addr(vram_base, 1'b1);
    for (int i = 0; i < VRAM_BURST; i++) begin
      vram_data[i] = 8'($random(seed));
      io_write(VDP_DATA_PORT, vram_data[i]);
    end
    vdp_set_addr(vram_base, 1'b0);
    for (int i = 0; i < VRAM_BURST; i++) begin
      io_read(VDP_DATA_PORT, rd);
      check_value("VRAM read", 16'(rd), 16'(vram_data[i]));
    end

    // Mode bits, every combination
    for (int combo = 0; combo < 8; combo++) begin
      vdp_write_reg(3'd0, {6'b000000, combo[0], 1'b0});
      vdp_write_reg(3'd1, {3'b000, combo[2], combo[1], 3'b000});
      @(negedge cpuClock);
      check_value("VDP mode", 16'(o_vdp_mode),
                  16'(expected_mode(combo[2], combo[1], combo[0])));
    end

    // Frame interrupt and status
    vdp_write_reg(3'd1, 8'h20);
    @(negedge cpuClock);
    check_value("n_int before vblank", 16'(o_n_int), 16'h0001);
    @(posedge cpuClock);
    i_vblank <= 1'b1;
    @(posedge cpuClock);
    i_vblank <= 1'b0;
    @(negedge cpuClock);
    check_value("n_int after vblank", 16'(o_n_int), 16'h0000);
    io_read(VDP_CTRL_PORT, rd);
    check_value("VDP status", 16'(rd), 16'h009F);
    wait_for_edge();
    @(posedge cpuClock);
    @(negedge cpuClock);
    check_value("n_int after status read", 16'(o_n_int), 16'h0001);

    // Joystick through PSG register 14
    @(posedge cpuClock);
    i_buttons <= 6'($random(seed));
    io_write(PSG_REG_PORT, 8'h0E);
    @(negedge cpuClock);
    check_value("PSG register", 16'(o_psg_reg), 16'd14);
    io_read(PSG_VAL_READ_PORT, rd);
    check_value("joystick", 16'(rd), 16'({2'b00, ~i_buttons}));

    // Value writes go out to the external PSG
    io_write(PSG_VAL_WRITE_PORT, 8'($random(seed)));
    check_value("PSG write strobes", 16'(psg_writes), 16'd1);

    // Cartridge ROM in page 1
    io_write(PPI_A_PORT, 8'h04);
    @(posedge cpuClock);
    i_rom_data <= 8'($random(seed));
    addr = {2'b01, 14'($random(seed))};
    bus_access(1'b0, 1'b0, addr, 8'h00, rd);
    check_value("ROM data", 16'(rd), 16'(i_rom_data));
    check_value("ROM address", 16'(o_rom_addr), 16'({1'b0, addr[13:0]}));

    finish_run();
  end

endmodule

`default_nettype wire

//--- hdl/msx_chipset.sv
`timescale 1ns/1ps
`default_nettype none

module msx_chipset
  import msx_io_pkg::*;
  import msx_vdp_pkg::*;
#(
  parameter int CLOCK_DIVIDE   = 7,
  parameter int VRAM_ADDR_BITS = 14
) (
  input  wire             cpuClock,
  input  wire             n_hard_reset,
  input  wire  cpu_addr_t i_addr,
  input  wire  cpu_data_t i_data_out,   // Z80 write data
  input  wire             i_n_wr,
  input  wire             i_n_rd,
  input  wire             i_n_mreq,
  input  wire             i_n_iorq,
  input  wire  cpu_data_t i_keyboard_row,
  input  wire  [5:0]      i_buttons,    // Active low
  input  wire             i_vblank,
  input  wire  cpu_data_t i_rom_data,
  input  wire             i_rom_32k,
  output cpu_data_t       o_data_in,    // Z80 read data
  output logic            o_cpu_clock_enable,
  output logic            o_cpu_clock_edge,
  output logic            o_n_int,
  output vdp_mode_e       o_vdp_mode,
  output logic [3:0]      o_keyboard_select,
  output logic [14:0]     o_rom_addr,
  output logic            o_psg_write,
  output psg_reg_t        o_psg_reg
);

  io_port_t  io_port;
  logic      io_wr, io_rd, mem_wr;
  logic      vdp_data_wr, vdp_data_rd, vdp_ctrl_wr, vdp_status_rd;
  logic      ppi_a_wr, ppi_c_wr, ppi_cmd_wr, psg_reg_wr;
  cpu_data_t ppi_a, ppi_c;
  cpu_data_t vdp_data, vdp_status, mem_data;
  cpu_data_t joystick;

  // ==================================================
  // Bus decode
  // ==================================================
  assign io_port = i_addr[7:0];
  assign io_wr   = !i_n_wr && !i_n_iorq;
  assign io_rd   = !i_n_rd && !i_n_iorq;
  assign mem_wr  = !i_n_wr && !i_n_mreq;

  assign vdp_data_wr   = io_wr && (io_port == VDP_DATA_PORT);
  assign vdp_data_rd   = io_rd && (io_port == VDP_DATA_PORT);
  assign vdp_ctrl_wr   = io_wr && (io_port == VDP_CTRL_PORT);
  assign vdp_status_rd = io_rd && (io_port == VDP_CTRL_PORT);
  assign ppi_a_wr      = io_wr && (io_port == PPI_A_PORT);
  assign ppi_c_wr      = io_wr && (io_port == PPI_C_PORT);
  assign ppi_cmd_wr    = io_wr && (io_port == PPI_CMD_PORT);
  assign psg_reg_wr    = io_wr && (io_port == PSG_REG_PORT);
  assign o_psg_write   = io_wr && (io_port == PSG_VAL_WRITE_PORT); // To external PSG

  cpu_clock_enable #(
    .CLOCK_DIVIDE (CLOCK_DIVIDE)
  ) i_clock_enable (
    .cpuClock           (cpuClock),
    .n_hard_reset       (n_hard_reset),
    .o_cpu_clock_enable (o_cpu_clock_enable),
    .o_cpu_clock_edge   (o_cpu_clock_edge)
  );

  vdp_port #(
    .VRAM_ADDR_BITS (VRAM_ADDR_BITS)
  ) i_vdp (
    .cpuClock         (cpuClock),
    .n_hard_reset     (n_hard_reset),
    .i_cpu_clock_edge (o_cpu_clock_edge),
    .i_data_wr        (vdp_data_wr),
    .i_data_rd        (vdp_data_rd),
    .i_ctrl_wr        (vdp_ctrl_wr),
    .i_status_rd      (vdp_status_rd),
    .i_data           (i_data_out),
    .i_vblank         (i_vblank),
    .o_data           (vdp_data),
    .o_status         (vdp_status),
    .o_mode           (o_vdp_mode),
    .o_n_int          (o_n_int)
  );

  ppi_psg_ports i_ppi_psg (
    .cpuClock         (cpuClock),
    .n_hard_reset     (n_hard_reset),
    .i_cpu_clock_edge (o_cpu_clock_edge),
    .i_ppi_a_wr       (ppi_a_wr),
    .i_ppi_c_wr       (ppi_c_wr),
    .i_ppi_cmd_wr     (ppi_cmd_wr),
    .i_psg_reg_wr     (psg_reg_wr),
    .i_data           (i_data_out),
    .o_ppi_a          (ppi_a),
    .o_ppi_c          (ppi_c),
    .o_psg_reg        (o_psg_reg)
  );

  slot_memory i_slot_memory (
    .cpuClock         (cpuClock),
    .i_cpu_clock_edge (o_cpu_clock_edge),
    .i_addr           (i_addr),
    .i_mem_wr         (mem_wr),
    .i_data           (i_data_out),
    .i_ppi_a          (ppi_a),
    .i_rom_32k        (i_rom_32k),
    .i_rom_data       (i_rom_data),
    .o_data           (mem_data),
    .o_rom_addr       (o_rom_addr)
  );

  assign o_keyboard_select = ppi_c[3:0]; // Row select for the matrix

  // ==================================================
  // CPU read multiplexer
  // ==================================================
  assign joystick = {2'b00, ~i_buttons};

  always_comb begin
    if (io_rd && io_port == PPI_A_PORT) begin
      o_data_in = ppi_a;
    end else if (io_rd && io_port == PPI_B_PORT) begin
      o_data_in = i_keyboard_row;
    end else if (io_rd && io_port == PPI_C_PORT) begin
      o_data_in = ppi_c;
    end else if (vdp_data_rd) begin
      o_data_in = vdp_data;
    end else if (vdp_status_rd) begin
      o_data_in = vdp_status;
    end else if (io_rd && io_port == PSG_VAL_READ_PORT && o_psg_reg == PSG_JOYSTICK_REG) begin
      o_data_in = joystick;
    end else begin
      o_data_in = mem_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/slot_memory.sv
`timescale 1ns/1ps
`default_nettype none

module slot_memory
  import msx_io_pkg::*;
(
  input  wire             cpuClock,
  input  wire             i_cpu_clock_edge,
  input  wire  cpu_addr_t i_addr,
  input  wire             i_mem_wr,
  input  wire  cpu_data_t i_data,
  input  wire  cpu_data_t i_ppi_a,
  input  wire             i_rom_32k,
  input  wire  cpu_data_t i_rom_data,
  output cpu_data_t       o_data,
  output logic [14:0]     o_rom_addr
);

  cpu_data_t   ram [65536];
  cpu_data_t   ram_q;
  logic [1:0]  page;
  slot_t       page_slot;
  logic        ram_we;

  initial begin
    for (int i = 0; i < 65536; i++) begin
      ram[i] = '0;
    end
  end

  assign page      = i_addr[15:14];
  assign page_slot = slot_t'(i_ppi_a[{page, 1'b0} +: 2]); // Two bits per page

  // Pages 2 and 3 only, pages 0 and 1 hold the BIOS in a real machine
  assign ram_we = i_cpu_clock_edge && i_mem_wr && page[1] && (page_slot == SLOT_RAM);

  always_ff @(posedge cpuClock) begin
    if (ram_we) begin
      ram[i_addr] <= i_data;
    end
    ram_q <= ram[i_addr];
  end

  // ==================================================
  // Read select
  // ==================================================
  always_comb begin
    if (page_slot == SLOT_RAM) begin
      o_data = ram_q;
    end else if (page == 2'd1 && page_slot == SLOT_CART) begin
      o_data = i_rom_data;
    end else if (page == 2'd2 && page_slot == SLOT_CART && i_rom_32k) begin
      o_data = i_rom_data; // Upper half of a 32K cartridge
    end else begin
      o_data = '0;
    end
  end

  assign o_rom_addr = 15'(i_addr - 16'h4000);

endmodule

`default_nettype wire

//--- hdl/ppi_psg_ports.sv
`timescale 1ns/1ps
`default_nettype none

module ppi_psg_ports
  import msx_io_pkg::*;
(
  input  wire             cpuClock,
  input  wire             n_hard_reset,
  input  wire             i_cpu_clock_edge,
  input  wire             i_ppi_a_wr,
  input  wire             i_ppi_c_wr,
  input  wire             i_ppi_cmd_wr,
  input  wire             i_psg_reg_wr,
  input  wire  cpu_data_t i_data,
  output cpu_data_t       o_ppi_a,
  output cpu_data_t       o_ppi_c,
  output psg_reg_t        o_psg_reg
);

  logic [2:0] bit_sel;

  // Bit set/reset command picks a port C bit
  assign bit_sel = i_data[3:1];

  // ==================================================
  // PPI ports A and C
  // ==================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      o_ppi_a <= '0;
      o_ppi_c <= '0;
    end else if (i_cpu_clock_edge) begin
      if (i_ppi_a_wr) o_ppi_a <= i_data; // Slot map

      if (i_ppi_c_wr) begin
        o_ppi_c <= i_data;
      end else if (i_ppi_cmd_wr && !i_data[7]) begin
        o_ppi_c[bit_sel] <= i_data[0];
      end
      // Mode set commands (bit 7 high) are ignored
    end
  end

  // PSG register select latch
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      o_psg_reg <= '0;
    end else if (i_cpu_clock_edge && i_psg_reg_wr) begin
      o_psg_reg <= psg_reg_t'(i_data[3:0]);
    end
  end

endmodule

`default_nettype wire

//--- hdl/vdp_port.sv
`timescale 1ns/1ps
`default_nettype none

module vdp_port
  import msx_io_pkg::*;
  import msx_vdp_pkg::*;
#(
  parameter int VRAM_ADDR_BITS = 14
) (
  input  wire             cpuClock,
  input  wire             n_hard_reset,
  input  wire             i_cpu_clock_edge,
  input  wire             i_data_wr,
  input  wire             i_data_rd,
  input  wire             i_ctrl_wr,
  input  wire             i_status_rd,
  input  wire  cpu_data_t i_data,
  input  wire             i_vblank,
  output cpu_data_t       o_data,
  output cpu_data_t       o_status,
  output vdp_mode_e       o_mode,
  output logic            o_n_int
);

  localparam int VRAM_DEPTH = 2 ** VRAM_ADDR_BITS;

  cpu_data_t                 vram [VRAM_DEPTH];
  logic [VRAM_ADDR_BITS-1:0] vram_addr;

  cpu_data_t      vdp_reg [VDP_REG_COUNT];
  vdp_reg_index_t reg_index;

  logic      second_byte;    // Next control write is the second byte
  cpu_data_t first_byte;
  logic      data_rd_q;
  logic      status_rd_q;
  logic      frame_flag;

  assign reg_index = vdp_reg_index_t'(i_data[2:0]);

  // ==================================================
  // Control port, registers and address counter
  // ==================================================
  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      second_byte <= 1'b0;
      vram_addr   <= '0;
      data_rd_q   <= 1'b0;
      status_rd_q <= 1'b0;
      frame_flag  <= 1'b0;
      for (int i = 0; i < VDP_REG_COUNT; i++) begin
        vdp_reg[i] <= '0;
      end
    end else begin
      if (i_vblank) frame_flag <= 1'b1; // Any cycle

      if (i_cpu_clock_edge) begin
        if (i_data_wr) vram_addr <= vram_addr + 1'b1;

        // Advance after the read has been seen by the CPU
        data_rd_q <= i_data_rd;
        if (data_rd_q && !i_data_rd) vram_addr <= vram_addr + 1'b1;

        status_rd_q <= i_status_rd;
        if (status_rd_q && !i_status_rd) frame_flag <= 1'b0;

        if (i_ctrl_wr) begin
          second_byte <= ~second_byte;
          if (!second_byte) begin
            first_byte <= i_data;
          end else if (!i_data[7]) begin
            // Bit 6 selects read or write setup, not needed here
            vram_addr <= VRAM_ADDR_BITS'({i_data[5:0], first_byte});
          end else if (i_data[5:0] < 6'(VDP_REG_COUNT)) begin
            vdp_reg[reg_index] <= first_byte;
          end
        end
      end
    end
  end

  // VRAM with registered read port
  always_ff @(posedge cpuClock) begin
    if (i_cpu_clock_edge && i_data_wr) begin
      vram[vram_addr] <= i_data;
    end
    o_data <= vram[vram_addr];
  end

  // ==================================================
  // Mode, status and interrupt
  // ==================================================
  always_comb begin
    if (vdp_reg[1][3]) begin
      o_mode = MULTICOLOR;
    end else if (vdp_reg[0][1]) begin
      o_mode = GRAPHIC2;
    end else if (vdp_reg[1][4]) begin
      o_mode = TEXT;
    end else begin
      o_mode = GRAPHIC1;
    end
  end

  // No sprite engine so the sprite fields are fixed
  assign o_status = {frame_flag, 2'b00, 5'b11111};

  assign o_n_int = ~(frame_flag & vdp_reg[1][5]); // R1 bit 5 enables the frame IRQ

  a_no_rd_wr : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    !(i_data_rd && i_data_wr));

endmodule

`default_nettype wire

//--- hdl/cpu_clock_enable.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_clock_enable #(
  parameter int CLOCK_DIVIDE = 7
) (
  input  wire  cpuClock,
  input  wire  n_hard_reset,
  output logic o_cpu_clock_enable,
  output logic o_cpu_clock_edge
);

  localparam int CW   = $clog2(CLOCK_DIVIDE);
  localparam int HALF = (CLOCK_DIVIDE + 1) / 2; // First count of the high part

  logic [CW-1:0] count;
  logic [CW-1:0] count_next;
  logic          enable_d;

  assign count_next = (count == CW'(CLOCK_DIVIDE - 1)) ? '0 : count + 1'b1;

  always_ff @(posedge cpuClock) begin
    if (!n_hard_reset) begin
      count              <= '0;
      o_cpu_clock_enable <= 1'b0;
      enable_d           <= 1'b0;
    end else begin
      count              <= count_next;
      o_cpu_clock_enable <= (count_next >= CW'(HALF)); // High for the later part
      enable_d           <= o_cpu_clock_enable;
    end
  end

  // Rising edge of the enable
  assign o_cpu_clock_edge = o_cpu_clock_enable & ~enable_d;

  // Strobe only where the count enters the high part, once per period
  a_edge_phase : assert property (@(posedge cpuClock) disable iff (!n_hard_reset)
    o_cpu_clock_edge |-> (count == CW'(HALF)));

endmodule

`default_nettype wire

//--- hdl/msx_vdp_pkg.sv
`default_nettype none

package msx_vdp_pkg;

  // Eight write-only registers behind the control port
  localparam int VDP_REG_COUNT = 8;

  typedef logic [2:0] vdp_reg_index_t;

  // Screen modes as decoded from registers 0 and 1
  typedef enum logic [1:0] {
    TEXT       = 2'd0,
    GRAPHIC1   = 2'd1,
    GRAPHIC2   = 2'd2,
    MULTICOLOR = 2'd3
  } vdp_mode_e;

endpackage

`default_nettype wire

//--- hdl/msx_io_pkg.sv
`default_nettype none

package msx_io_pkg;

  // Z80 bus widths
  typedef logic [15:0] cpu_addr_t;
  typedef logic [7:0]  cpu_data_t;
  typedef logic [7:0]  io_port_t;

  // ==================================================
  // MSX I/O port map
  // ==================================================
  localparam io_port_t VDP_DATA_PORT      = 8'h98;
  localparam io_port_t VDP_CTRL_PORT      = 8'h99; // Control write, status read

  localparam io_port_t PSG_REG_PORT       = 8'hA0;
  localparam io_port_t PSG_VAL_WRITE_PORT = 8'hA1;
  localparam io_port_t PSG_VAL_READ_PORT  = 8'hA2;

  localparam io_port_t PPI_A_PORT         = 8'hA8; // Primary slot select
  localparam io_port_t PPI_B_PORT         = 8'hA9; // Keyboard row in
  localparam io_port_t PPI_C_PORT         = 8'hAA;
  localparam io_port_t PPI_CMD_PORT       = 8'hAB;

  // ==================================================
  // Slots and PSG
  // ==================================================
  typedef logic [1:0] slot_t;

  localparam slot_t SLOT_RAM  = 2'd0; // 64K main RAM
  localparam slot_t SLOT_CART = 2'd1; // Cartridge ROM

  typedef logic [3:0] psg_reg_t;

  // Register 14 reads the joystick port
  localparam psg_reg_t PSG_JOYSTICK_REG = 4'd14;

endpackage

`default_nettype wire
